// ==== csa_cfg_pkg.sv ====
`default_nettype none

package csa_cfg_pkg;

	// ==============================
	// word and field widths
	// ==============================

	// host side word, every job and result field is a multiple of it
	localparam int WORD_W = 32;

	// seed, candidate, mask and value all share this width
	localparam int DATA_W = 2 * WORD_W;

	localparam int JOB_W = 5 * WORD_W;
	localparam int RES_W = 7 * WORD_W;

	// ==============================
	// queue depths
	// ==============================

	localparam int IN_DEPTH  = 8;
	localparam int OUT_DEPTH = 8;

	// ==============================
	// reduced mixing cipher
	// ==============================

	localparam int ROUNDS  = 4;
	localparam int ROT_AMT = 13;

	// odd additive constant so every round changes the low bit pattern
	localparam logic [DATA_W-1:0] ROUND_C = 64'h9e37_79b9_7f4a_7c15;

	// key trial FSM state codes
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_TRIAL = 2'd2;
	localparam logic [1:0] ST_EMIT  = 2'd3;

endpackage

`default_nettype wire

// ==== csa_job_pkg.sv ====
`default_nettype none

package csa_job_pkg;

	// ==============================
	// job word, five bus words
	// ==============================

	// first member lands in the most significant word
	typedef struct packed {
		logic [csa_cfg_pkg::WORD_W-1:0] times_start;
		logic [csa_cfg_pkg::WORD_W-1:0] times;
		logic [csa_cfg_pkg::DATA_W-1:0] seed;
		logic [csa_cfg_pkg::WORD_W-1:0] block;
	} job_fields_t;

	// the input FIFO stores raw bits, the core reads the fields
	typedef union packed {
		logic [csa_cfg_pkg::JOB_W-1:0] raw;
		job_fields_t                    f;
	} job_word_u;

	// ==============================
	// result word, seven bus words
	// ==============================

	// cand is zero and hit_key is times_start for a job with no trials
	typedef struct packed {
		logic [csa_cfg_pkg::DATA_W-1:0] cand;
		logic [csa_cfg_pkg::WORD_W-1:0] status;
		logic [csa_cfg_pkg::WORD_W-1:0] hit_key;
		logic [csa_cfg_pkg::DATA_W-1:0] seed;
		logic [csa_cfg_pkg::WORD_W-1:0] block;
	} res_fields_t;

	// status bit 0 is the hit flag, the other bits stay zero
	typedef union packed {
		logic [csa_cfg_pkg::RES_W-1:0] raw;
		res_fields_t                    f;
	} res_word_u;

endpackage

`default_nettype wire

// ==== fifo_rd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// read side of a FIFO, rdata is valid while rvalid is high
interface fifo_rd_if #(
	parameter int WIDTH = 32
);

	logic             ren;
	logic [WIDTH-1:0] rdata;
	logic             empty;
	logic             rvalid;

	modport fifo (
		input  ren,
		output rdata,
		output empty,
		output rvalid
	);

	modport reader (
		output ren,
		input  rdata,
		input  empty,
		input  rvalid
	);

endinterface

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst_n,

	input  logic             wen_i,
	input  logic [WIDTH-1:0] wdata_i,
	output logic             full_o,

	fifo_rd_if.fifo          rd
);

	logic [WIDTH-1:0]           mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       wr_ok;
	logic                       rd_ok;

	// requests against a full or empty buffer are dropped here
	assign wr_ok = wen_i && !full_o;
	assign rd_ok = rd.ren && !rd.empty;

	assign full_o   = (count == DEPTH);
	assign rd.empty = (count == '0);

	// storage and read data register
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wdata_i;
		end
		if (rd_ok) begin
			rd.rdata <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			rd.rvalid <= 1'b0;
		end else begin
			rd.rvalid <= rd_ok;

			if (wr_ok) begin
				wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_ok) begin
				rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end

			// a read and a write in the same cycle leave the count alone
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== trial_cipher.sv ====
`timescale 1ns/1ps
`default_nettype none

module trial_cipher (
	input  logic [csa_cfg_pkg::DATA_W-1:0] seed_i,
	input  logic [csa_cfg_pkg::WORD_W-1:0] key_i,
	output logic [csa_cfg_pkg::DATA_W-1:0] cand_o
);

	import csa_cfg_pkg::*;

	logic [DATA_W-1:0] key_word;
	logic [DATA_W-1:0] stage [ROUNDS+1];

	// key in the upper half, its inverse in the lower half
	assign key_word = {key_i, ~key_i};

	assign stage[0] = seed_i;

	// ==============================
	// unrolled rounds
	// ==============================

	// every round sees the same key word, so the whole chain
	// settles within one clock and a new key can enter each cycle
	for (genvar r = 0; r < ROUNDS; r++) begin : g_round
		logic [DATA_W-1:0] mixed;
		logic [DATA_W-1:0] rotated;

		assign mixed = stage[r] ^ key_word;

		// rotate left by ROT_AMT
		assign rotated = {
			mixed[DATA_W-ROT_AMT-1:0],
			mixed[DATA_W-1:DATA_W-ROT_AMT]
		};

		// carry out of bit 63 is dropped
		assign stage[r+1] = rotated + ROUND_C;
	end

	assign cand_o = stage[ROUNDS];

endmodule

`default_nettype wire

// ==== key_trial_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_trial_core (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic [csa_cfg_pkg::DATA_W-1:0] mask_i,
	input  logic [csa_cfg_pkg::DATA_W-1:0] value_i,

	fifo_rd_if.reader                      job,

	output logic                           res_wen_o,
	output csa_job_pkg::res_word_u         res_wdata_o,
	input  logic                           res_full_i
);

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	logic [1:0]        state;
	job_word_u         job_w;
	res_word_u         res_q;
	logic [WORD_W-1:0] key_q;
	logic [WORD_W-1:0] remain_q;
	logic [DATA_W-1:0] cand;
	logic              hit;

	assign job_w.raw = job.rdata;

	// seed is taken from the result register, where it is latched at fetch
	trial_cipher u_cipher (
		.seed_i (res_q.f.seed),
		.key_i  (key_q),
		.cand_o (cand)
	);

	assign hit = (cand & mask_i) == (value_i & mask_i);

	// only pop a job when its result has somewhere to go
	assign job.ren = (state == ST_IDLE) && !job.empty && !res_full_i;

	assign res_wen_o   = (state == ST_EMIT) && !res_full_i;
	assign res_wdata_o = res_q;

	// ==============================
	// control FSM
	// ==============================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job.ren) begin
						state <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					if (job.rvalid) begin
						state <= (job_w.f.times == '0) ? ST_EMIT : ST_TRIAL;
					end
				end
				ST_TRIAL: begin
					// stop on the first hit or after the last key
					if (hit || remain_q == 1) begin
						state <= ST_EMIT;
					end
				end
				ST_EMIT: begin
					if (res_wen_o) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ==============================
	// job and result payload
	// ==============================

	always_ff @(posedge clk) begin
		if (state == ST_FETCH && job.rvalid) begin
			key_q    <= job_w.f.times_start;
			remain_q <= job_w.f.times;

			res_q.f.block <= job_w.f.block;
			res_q.f.seed  <= job_w.f.seed;

			// this is already the result for a zero trial count
			res_q.f.hit_key <= job_w.f.times_start;
			res_q.f.status  <= '0;
			res_q.f.cand    <= '0;
		end

		if (state == ST_TRIAL) begin
			res_q.f.cand    <= cand;
			res_q.f.hit_key <= key_q;
			res_q.f.status  <= {{(WORD_W-1){1'b0}}, hit};

			key_q    <= key_q + 1'b1;
			remain_q <= remain_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== csa_trial_wrap.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_trial_wrap (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic [csa_cfg_pkg::DATA_W-1:0] mask_i,
	input  logic [csa_cfg_pkg::DATA_W-1:0] value_i,

	input  logic                           job_wr_i,
	input  logic [csa_cfg_pkg::JOB_W-1:0]  job_data_i,
	output logic                           job_full_o,
	output logic                           job_empty_o,

	input  logic                           res_rd_i,
	output logic                           res_valid_o,
	output logic [csa_cfg_pkg::RES_W-1:0]  res_data_o
);

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	fifo_rd_if #(.WIDTH(JOB_W)) job_rd ();
	fifo_rd_if #(.WIDTH(RES_W)) res_rd ();

	logic      res_wen;
	logic      res_full;
	res_word_u res_wdata;

	// host writes jobs straight into this one
	sync_fifo #(
		.WIDTH (JOB_W),
		.DEPTH (IN_DEPTH)
	) u_job_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wen_i   (job_wr_i),
		.wdata_i (job_data_i),
		.full_o  (job_full_o),
		.rd      (job_rd.fifo)
	);

	sync_fifo #(
		.WIDTH (RES_W),
		.DEPTH (OUT_DEPTH)
	) u_res_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.wen_i   (res_wen),
		.wdata_i (res_wdata.raw),
		.full_o  (res_full),
		.rd      (res_rd.fifo)
	);

	key_trial_core u_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.mask_i      (mask_i),
		.value_i     (value_i),
		.job         (job_rd.reader),
		.res_wen_o   (res_wen),
		.res_wdata_o (res_wdata),
		.res_full_i  (res_full)
	);

	assign job_empty_o = job_rd.empty;

	// result read side goes out as plain pins
	assign res_rd.ren  = res_rd_i;
	assign res_valid_o = !res_rd.empty;
	assign res_data_o  = res_rd.rdata;

endmodule

`default_nettype wire

// ==== tb_csa_model.svh ====
`ifndef TB_CSA_MODEL_SVH
`define TB_CSA_MODEL_SVH

// ==============================
// reference model
// ==============================

// candidate for one key with all rounds chained from the seed
function automatic logic [DATA_W-1:0] model_cand(
	input logic [DATA_W-1:0] seed_v,
	input logic [WORD_W-1:0] key_v
);
	logic [DATA_W-1:0] x;
	logic [DATA_W-1:0] kw;
	x  = seed_v;
	kw = {key_v, ~key_v};
	for (int r = 0; r < ROUNDS; r++) begin
		x = x ^ kw;
		x = (x << ROT_AMT) | (x >> (DATA_W - ROT_AMT));
		x = x + ROUND_C;
	end
	return x;
endfunction

// walks the keys of one job until the first hit or the last key
function automatic res_word_u model_result(
	input job_word_u         job,
	input logic [DATA_W-1:0] mask_v,
	input logic [DATA_W-1:0] value_v
);
	res_word_u         res;
	logic [WORD_W-1:0] key;
	logic [DATA_W-1:0] c;
	res.raw       = '0;
	res.f.block   = job.f.block;
	res.f.seed    = job.f.seed;
	res.f.hit_key = job.f.times_start;
	for (int unsigned i = 0; i < job.f.times; i++) begin
		key           = job.f.times_start + i;
		c             = model_cand(job.f.seed, key);
		res.f.cand    = c;
		res.f.hit_key = key;
		if ((c & mask_v) == (value_v & mask_v)) begin
			res.f.status[0] = 1'b1;
			break;
		end
	end
	return res;
endfunction

// ==============================
// compare tasks
// ==============================

task automatic check_field(input string name, input logic [DATA_W-1:0] exp_v,
	input logic [DATA_W-1:0] act_v);
	if (act_v !== exp_v) begin
		stop_with_failure($sformatf("MISMATCH at %0t ns: %s expected %h got %h",
			$time, name, exp_v, act_v));
	end
endtask

task automatic check_result(input res_word_u exp_r, input res_word_u act_r);
	check_field("res_data_o.block", exp_r.f.block, act_r.f.block);
	check_field("res_data_o.seed", exp_r.f.seed, act_r.f.seed);
	check_field("res_data_o.hit_key", exp_r.f.hit_key, act_r.f.hit_key);
	check_field("res_data_o.status", exp_r.f.status, act_r.f.status);
	check_field("res_data_o.cand", exp_r.f.cand, act_r.f.cand);
endtask

task automatic check_flag(input string name, input logic exp_b, input logic act_b);
	if (act_b !== exp_b) begin
		stop_with_failure($sformatf("MISMATCH at %0t ns: %s expected %b got %b",
			$time, name, exp_b, act_b));
	end
endtask

`endif

// ==== tb_csa_trial.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csa_trial;

	import csa_cfg_pkg::*;
	import csa_job_pkg::*;

	localparam int DRAIN_TIMEOUT = 4000;
	localparam int FULL_TIMEOUT  = 64;

	logic              clk;
	logic              rst_n;
	logic [DATA_W-1:0] mask;
	logic [DATA_W-1:0] value;
	logic              job_wr;
	logic [JOB_W-1:0]  job_data;
	logic              job_full;
	logic              job_empty;
	logic              res_rd;
	logic              res_valid;
	logic [RES_W-1:0]  res_data;

	res_word_u expect_q [$];
	int        seed = 23;
	logic      drain_en;

	csa_trial_wrap u_csa_trial_wrap (
		.clk         (clk),
		.rst_n       (rst_n),
		.mask_i      (mask),
		.value_i     (value),
		.job_wr_i    (job_wr),
		.job_data_i  (job_data),
		.job_full_o  (job_full),
		.job_empty_o (job_empty),
		.res_rd_i    (res_rd),
		.res_valid_o (res_valid),
		.res_data_o  (res_data)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_csa_model.svh"

	function automatic logic [DATA_W-1:0] rand_data();
		return {$random(seed), $random(seed)};
	endfunction

	task automatic make_job(output job_word_u j, input int max_times);
		j.f.times_start = $random(seed);
		j.f.times       = $unsigned($random(seed)) % (max_times + 1);
		j.f.seed        = rand_data();
		j.f.block       = $random(seed);
	endtask

	// called on a falling edge, the expected result is queued with the write
	task automatic write_job(input job_word_u j);
		int waited;
		waited = 0;
		while (job_full) begin
			@(negedge clk);
			waited++;
			if (waited > FULL_TIMEOUT) begin
				stop_with_failure("job FIFO stayed full and the job could not be written");
			end
		end
		job_wr   = 1'b1;
		job_data = j.raw;
		expect_q.push_back(model_result(j, mask, value));
		@(negedge clk);
		job_wr = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (expect_q.size() != 0) begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_TIMEOUT) begin
				stop_with_failure("timed out waiting for the outstanding results");
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// reads whenever a result is waiting and checks it against the queue head
	initial begin : drain_results
		logic      read_issued;
		res_word_u got;
		read_issued = 1'b0;
		res_rd      = 1'b0;
		forever begin
			@(negedge clk);
			if (read_issued) begin
				if (expect_q.size() == 0) begin
					stop_with_failure("a result came out with no job outstanding");
				end
				got.raw = res_data;
				check_result(expect_q.pop_front(), got);
			end
			read_issued = drain_en && res_valid && rst_n;
			res_rd      = read_issued;
		end
	end

	initial begin : stimulus
		job_word_u         j;
		res_word_u         probe;
		logic [WORD_W-1:0] hit_k;
		int                tries;
		int                waited;
		logic              full_seen;
		rst_n    = 1'b0;
		mask     = '0;
		value    = '0;
		job_wr   = 1'b0;
		job_data = '0;
		drain_en = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_flag("job_empty_o", 1'b1, job_empty);
		check_flag("job_full_o", 1'b0, job_full);
		check_flag("res_valid_o", 1'b0, res_valid);

		// ==============================
		// planted hits under a full mask
		drain_en = 1'b1;
		for (int n = 0; n < 3; n++) begin
			make_job(j, 0);
			j.f.times = 12;
			hit_k     = j.f.times_start + 3 + n;
			mask      = '1;
			value     = model_cand(j.f.seed, hit_k);
			probe     = model_result(j, mask, value);
			if (probe.f.hit_key != hit_k) begin
				stop_with_failure("an earlier key already matches the planted candidate");
			end
			write_job(j);
			wait_drained();
		end

		// ==============================
		// misses, then a job with no trials
		for (int n = 0; n < 4; n++) begin
			make_job(j, 7);
			j.f.times += 1;
			tries = 0;
			do begin
				mask  = rand_data() & rand_data();
				value = rand_data();
				probe = model_result(j, mask, value);
				tries++;
			end while (probe.f.status[0] && tries < 32);
			if (probe.f.status[0]) begin
				stop_with_failure("no mask and value pair was found that misses every key");
			end
			write_job(j);
			wait_drained();
		end
		make_job(j, 0);
		write_job(j);
		wait_drained();

		// ==============================
		// random stream in groups that share a sparse mask
		for (int g = 0; g < 4; g++) begin
			mask  = rand_data() & rand_data() & rand_data() & rand_data();
			value = rand_data();
			for (int n = 0; n < 10; n++) begin
				make_job(j, 24);
				write_job(j);
			end
			wait_drained();
		end

		// ==============================
		// no reads until the input side backs up
		drain_en  = 1'b0;
		mask      = rand_data() & rand_data();
		value     = rand_data();
		full_seen = 1'b0;
		for (int n = 0; n < 20; n++) begin
			waited = 0;
			while (job_full && waited < FULL_TIMEOUT) begin
				full_seen = 1'b1;
				@(negedge clk);
				waited++;
			end
			if (job_full) begin
				break;
			end
			make_job(j, 4);
			write_job(j);
		end
		check_flag("job_full_o seen high", 1'b1, full_seen);
		drain_en = 1'b1;
		wait_drained();
		repeat (20) @(negedge clk);
		check_flag("res_valid_o after the drain", 1'b0, res_valid);
		check_flag("job_empty_o after the drain", 1'b1, job_empty);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
csa_cfg_pkg.sv
csa_job_pkg.sv
fifo_rd_if.sv
sync_fifo.sv
trial_cipher.sv
key_trial_core.sv
csa_trial_wrap.sv
tb_csa_trial.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_csa_trial
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
